// ==== btb/btb.sv ====
// ----------------------------------------
// branch target buffer core
// REQ/RESP lookup with way 0 priority
// update 0/1 write pipeline with LRU RMW
// ----------------------------------------
`default_nettype none
`timescale 1ns/100ps

module btb #(
    parameter int SETS    = btb_cfg_pkg::BTB_SETS_DEFAULT,
    parameter int ENTRIES = btb_cfg_pkg::BTB_ENTRIES_DEFAULT
) (
    input  logic                                  CLK,
    input  logic                                  nRST,
    input  btb_types_pkg::btb_req_t               req,
    input  btb_types_pkg::btb_update0_t           update0,
    input  btb_types_pkg::btb_update1_t           update1,
    output logic                                  valid_resp,
    output logic [ENTRIES-1:0]                    hit,
    output logic [ENTRIES-1:0][btb_cfg_pkg::BTB_PRED_INFO_WIDTH-1:0] pred_info,
    output btb_types_pkg::btb_way_e [ENTRIES-1:0] pred_lru,
    output logic [ENTRIES-1:0][btb_cfg_pkg::BTB_TARGET_WIDTH-1:0]    target
);

    localparam int LOG_SETS    = $clog2(SETS);
    localparam int LOG_ENTRIES = $clog2(ENTRIES);
    // slot field starts at pc bit 1, set index right above it
    localparam int INDEX_LSB   = LOG_ENTRIES + 1;
    localparam int TAG_LSB     = INDEX_LSB + LOG_SETS;
    localparam int ASSOC       = btb_cfg_pkg::BTB_ASSOC;
    localparam int TAG_W       = btb_cfg_pkg::BTB_TAG_WIDTH;

    // REQ stage
    logic [LOG_SETS-1:0] index_req;
    logic [TAG_W-1:0]    tag_req;
    logic [ENTRIES-1:0]  lru_req;

    // RESP stage
    logic [ENTRIES-1:0][TAG_W-1:0]                        tag_resp;
    logic [ENTRIES-1:0]                                   lru_resp;
    btb_types_pkg::btb_entry_t [ENTRIES-1:0][ASSOC-1:0]   entry_resp;
    logic [ENTRIES-1:0][ASSOC-1:0]                        match_resp;

    // update 0
    logic [LOG_SETS-1:0]    u0_index;
    logic [LOG_ENTRIES-1:0] u0_slot;
    logic [TAG_W-1:0]       u0_tag;
    logic [ENTRIES-1:0]     u0_lru_raw;
    logic [ENTRIES-1:0]     u0_old_lru;

    // update 1
    logic                      u1_valid;
    logic [LOG_SETS-1:0]       u1_index;
    logic [LOG_ENTRIES-1:0]    u1_slot;
    logic [TAG_W-1:0]          u1_tag;
    logic [ENTRIES-1:0]        u1_old_lru;
    logic [ENTRIES-1:0]        u1_new_lru;
    btb_types_pkg::btb_entry_t u1_entry;
    logic [ENTRIES-1:0][ASSOC-1:0][btb_cfg_pkg::BTB_ENTRY_BYTES-1:0] u1_wmask;

    // ----------------------------------------
    // REQ stage
    // ----------------------------------------

    assign index_req = req.full_pc[TAG_LSB-1:INDEX_LSB];

    btb_tag_hash #(
        .INDEX_LSB_SUM(TAG_LSB)
    ) req_hash (
        .pc   (req.full_pc),
        .asid (req.asid),
        .tag  (tag_req)
    );

    // ----------------------------------------
    // RESP stage
    // ----------------------------------------

    // tag copied per slot, lru word sampled off the async port
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_resp <= 1'b0;
            tag_resp   <= '0;
            lru_resp   <= '0;
        end else begin
            valid_resp <= req.valid;
            tag_resp   <= {ENTRIES{tag_req}};
            lru_resp   <= lru_req;
        end
    end

    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            for (int w = 0; w < ASSOC; w++) begin
                match_resp[i][w] = (entry_resp[i][w].tag == tag_resp[i]);
            end
            hit[i] = |match_resp[i];
            // way 0 wins on a double match
            if (match_resp[i][0]) begin
                pred_info[i] = entry_resp[i][0].pred_info;
                target[i]    = entry_resp[i][0].target;
                pred_lru[i]  = btb_types_pkg::WAY0;
            end else if (match_resp[i][1]) begin
                pred_info[i] = entry_resp[i][1].pred_info;
                target[i]    = entry_resp[i][1].target;
                pred_lru[i]  = btb_types_pkg::WAY1;
            end else begin
                // miss shows way 0 and the stored hint
                pred_info[i] = entry_resp[i][0].pred_info;
                target[i]    = entry_resp[i][0].target;
                pred_lru[i]  = btb_types_pkg::btb_way_e'(lru_resp[i]);
            end
        end
    end

    // ----------------------------------------
    // update 0
    // ----------------------------------------

    assign u0_index = update0.start_pc[TAG_LSB-1:INDEX_LSB];
    assign u0_slot  = update0.start_pc[INDEX_LSB-1:1];

    // asid comes from the lookup side
    btb_tag_hash #(
        .INDEX_LSB_SUM(TAG_LSB)
    ) update_hash (
        .pc   (update0.start_pc),
        .asid (req.asid),
        .tag  (u0_tag)
    );

    // back to back updates on one set
    // the word being written this edge is the real old word
    assign u0_old_lru = (u1_valid && (u1_index == u0_index)) ? u1_new_lru : u0_lru_raw;

    // ----------------------------------------
    // update 1
    // ----------------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            u1_valid   <= 1'b0;
            u1_index   <= '0;
            u1_slot    <= '0;
            u1_tag     <= '0;
            u1_old_lru <= '0;
        end else begin
            u1_valid   <= update0.valid;
            u1_index   <= u0_index;
            u1_slot    <= u0_slot;
            u1_tag     <= u0_tag;
            u1_old_lru <= u0_old_lru;
        end
    end

    always_comb begin
        u1_entry.pred_info = update1.pred_info;
        u1_entry.tag       = u1_tag;
        u1_entry.target    = update1.target_pc[btb_cfg_pkg::BTB_TARGET_WIDTH:1];
        // replace one hint bit
        u1_new_lru          = u1_old_lru;
        u1_new_lru[u1_slot] = update1.lru;
        // all bytes of one slot and one way
        u1_wmask = '0;
        u1_wmask[u1_slot][update1.lru] = {btb_cfg_pkg::BTB_ENTRY_BYTES{u1_valid}};
    end

    // ----------------------------------------
    // storage
    // ----------------------------------------

    // one block RAM per slot, both ways side by side
    for (genvar g = 0; g < ENTRIES; g++) begin : g_slot
        bram_1rport_1wport #(
            .INNER_WIDTH (ASSOC * btb_cfg_pkg::BTB_ENTRY_WIDTH),
            .OUTER_WIDTH (SETS)
        ) entry_ram (
            .CLK      (CLK),
            .nRST     (nRST),
            .ren      (req.valid),
            .rindex   (index_req),
            .rdata    (entry_resp[g]),
            .wen_byte (u1_wmask[g]),
            .windex   (u1_index),
            .wdata    ({ASSOC{u1_entry}})
        );
    end

    // port 0 for lookup, port 1 for the update RMW
    distram_2rport_1wport #(
        .INNER_WIDTH (ENTRIES),
        .OUTER_WIDTH (SETS)
    ) lru_ram (
        .CLK          (CLK),
        .nRST         (nRST),
        .port0_rindex (index_req),
        .port0_rdata  (lru_req),
        .port1_rindex (u0_index),
        .port1_rdata  (u0_lru_raw),
        .wen          (u1_valid),
        .windex       (u1_index),
        .wdata        (u1_new_lru)
    );

    // ----------------------------------------
    // checks
    // ----------------------------------------

    // every response traces back to a sampled request
    a_resp_has_req: assert property (@(posedge CLK) disable iff (!nRST)
        valid_resp |-> $past(req.valid));

    a_u1_slot_range: assert property (@(posedge CLK) disable iff (!nRST)
        u1_valid |-> (int'(u1_slot) < ENTRIES));

endmodule

`default_nettype wire

// ==== btb/btb_tag_hash.sv ====
// ----------------------------------------
// tag hash
// XOR fold of upper pc bits with the ASID
// ----------------------------------------
`default_nettype none
`timescale 1ns/100ps

module btb_tag_hash #(
    parameter int INDEX_LSB_SUM = 10
) (
    input  logic [btb_cfg_pkg::BTB_PC_WIDTH-1:0]  pc,
    input  logic [btb_cfg_pkg::ASID_WIDTH-1:0]    asid,
    output logic [btb_cfg_pkg::BTB_TAG_WIDTH-1:0] tag
);

    localparam int TAG_W      = btb_cfg_pkg::BTB_TAG_WIDTH;
    localparam int UPPER_BITS = btb_cfg_pkg::BTB_PC_WIDTH - INDEX_LSB_SUM;
    // round up to whole chunks
    localparam int NUM_CHUNKS = (UPPER_BITS + TAG_W - 1) / TAG_W;

    logic [NUM_CHUNKS*TAG_W-1:0] upper_ext;

    always_comb begin
        // zero extend the bits above the set index
        upper_ext = '0;
        upper_ext[UPPER_BITS-1:0] = pc[btb_cfg_pkg::BTB_PC_WIDTH-1:INDEX_LSB_SUM];
        // low asid bits seed the fold
        tag = asid[TAG_W-1:0];
        for (int c = 0; c < NUM_CHUNKS; c++) begin
            tag = tag ^ upper_ext[c*TAG_W +: TAG_W];
        end
    end

endmodule

`default_nettype wire

// ==== btb_top.f ====
common/btb_cfg_pkg.sv
common/btb_types_pkg.sv
btb/btb_tag_hash.sv
logic/bram_1rport_1wport.sv
logic/distram_2rport_1wport.sv
btb/btb.sv
logic/btb_top.sv
tb/btb_tb.sv

// ==== common/btb_cfg_pkg.sv ====
// ----------------------------------------
// branch target buffer configuration
// table geometry defaults, entry field
// widths and address widths
// ----------------------------------------
`default_nettype none

package btb_cfg_pkg;

    // ----------------------------------------
    // table geometry
    // ----------------------------------------

    // sets per table
    localparam int BTB_SETS_DEFAULT = 64;
    // instruction slots per fetch block
    localparam int BTB_ENTRIES_DEFAULT = 8;
    // ways per slot, the LRU hint is one bit so this stays at 2
    localparam int BTB_ASSOC = 2;

    // ----------------------------------------
    // entry fields
    // ----------------------------------------

    localparam int BTB_PRED_INFO_WIDTH = 8;
    localparam int BTB_TAG_WIDTH = 8;
    // target keeps pc bits [16:1]
    localparam int BTB_TARGET_WIDTH = 16;

    // one packed entry, 32 bits
    localparam int BTB_ENTRY_WIDTH = BTB_PRED_INFO_WIDTH + BTB_TAG_WIDTH + BTB_TARGET_WIDTH;
    // byte lanes per entry
    localparam int BTB_ENTRY_BYTES = BTB_ENTRY_WIDTH / 8;

    // ----------------------------------------
    // address widths
    // ----------------------------------------

    localparam int BTB_PC_WIDTH = 32;
    localparam int ASID_WIDTH = 9;

endpackage

`default_nettype wire

// ==== common/btb_types_pkg.sv ====
// ----------------------------------------
// branch target buffer traffic types
// way enum, stored entry, lookup request
// and the two update stage structs
// ----------------------------------------
`default_nettype none

package btb_types_pkg;

    // way select and LRU hint
    typedef enum logic {
        WAY0 = 1'b0,
        WAY1 = 1'b1
    } btb_way_e;

    // one stored way of one slot
    // field order sets the byte lanes in the block RAM
    typedef struct packed {
        logic [btb_cfg_pkg::BTB_PRED_INFO_WIDTH-1:0] pred_info;
        logic [btb_cfg_pkg::BTB_TAG_WIDTH-1:0]       tag;
        logic [btb_cfg_pkg::BTB_TARGET_WIDTH-1:0]    target;
    } btb_entry_t;

    // ----------------------------------------
    // pipeline inputs
    // ----------------------------------------

    // REQ stage lookup
    typedef struct packed {
        logic                                 valid;
        logic [btb_cfg_pkg::BTB_PC_WIDTH-1:0] full_pc;
        logic [btb_cfg_pkg::ASID_WIDTH-1:0]   asid;
    } btb_req_t;

    // update 0, start of fetch block
    typedef struct packed {
        logic                                 valid;
        logic [btb_cfg_pkg::BTB_PC_WIDTH-1:0] start_pc;
    } btb_update0_t;

    // update 1, payload of the write
    // no valid bit, qualified by update 0 one cycle earlier
    typedef struct packed {
        logic [btb_cfg_pkg::BTB_PRED_INFO_WIDTH-1:0] pred_info;
        btb_way_e                                    lru;
        logic [btb_cfg_pkg::BTB_PC_WIDTH-1:0]        target_pc;
    } btb_update1_t;

endpackage

`default_nettype wire

// ==== logic/bram_1rport_1wport.sv ====
// ----------------------------------------
// block RAM, one read and one write port
// registered read-first output
// byte lane write enables
// ----------------------------------------
`default_nettype none
`timescale 1ns/100ps

module bram_1rport_1wport #(
    parameter int INNER_WIDTH = 64,
    parameter int OUTER_WIDTH = 64
) (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic                           ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0] rindex,
    output logic [INNER_WIDTH-1:0]         rdata,
    input  logic [INNER_WIDTH/8-1:0]       wen_byte,
    input  logic [$clog2(OUTER_WIDTH)-1:0] windex,
    input  logic [INNER_WIDTH-1:0]         wdata
);

    localparam int NUM_BYTES = INNER_WIDTH / 8;

    logic [NUM_BYTES-1:0][7:0] mem [OUTER_WIDTH];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < OUTER_WIDTH; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else begin
            // read sees the word from before this edge
            if (ren) begin
                rdata <= mem[rindex];
            end
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (wen_byte[b]) begin
                    mem[windex][b] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // non power of two depth leaves holes in the index
    a_windex_range: assert property (@(posedge CLK) disable iff (!nRST)
        (|wen_byte) |-> (int'(windex) < OUTER_WIDTH));

endmodule

`default_nettype wire

// ==== logic/btb_top.sv ====
// ----------------------------------------
// branch target buffer top level
// sets the table geometry and hooks the
// request and update structs to the core
// ----------------------------------------
`default_nettype none
`timescale 1ns/100ps

module btb_top #(
    // sets per table, power of two
    parameter int SETS    = btb_cfg_pkg::BTB_SETS_DEFAULT,
    // slots per fetch block, power of two
    parameter int ENTRIES = btb_cfg_pkg::BTB_ENTRIES_DEFAULT
) (
    input  logic                                  CLK,
    input  logic                                  nRST,

    // lookup and update pipelines
    input  btb_types_pkg::btb_req_t               req,
    input  btb_types_pkg::btb_update0_t           update0,
    input  btb_types_pkg::btb_update1_t           update1,

    // RESP stage, one cycle after req
    output logic                                  valid_resp,
    output logic [ENTRIES-1:0]                    hit,
    output logic [ENTRIES-1:0][btb_cfg_pkg::BTB_PRED_INFO_WIDTH-1:0] pred_info,
    output btb_types_pkg::btb_way_e [ENTRIES-1:0] pred_lru,
    output logic [ENTRIES-1:0][btb_cfg_pkg::BTB_TARGET_WIDTH-1:0]    target
);

    // ----------------------------------------
    // buffer core
    // ----------------------------------------

    // geometry passed straight down
    btb #(
        .SETS    (SETS),
        .ENTRIES (ENTRIES)
    ) buffer (
        .CLK        (CLK),
        .nRST       (nRST),
        // REQ stage
        .req        (req),
        // update 0 then update 1 a cycle later
        .update0    (update0),
        .update1    (update1),
        // per slot results
        .valid_resp (valid_resp),
        .hit        (hit),
        .pred_info  (pred_info),
        .pred_lru   (pred_lru),
        .target     (target)
    );

endmodule

`default_nettype wire

// ==== logic/distram_2rport_1wport.sv ====
// ----------------------------------------
// distributed RAM
// two async read ports, one clocked write
// ----------------------------------------
`default_nettype none
`timescale 1ns/100ps

module distram_2rport_1wport #(
    parameter int INNER_WIDTH = 8,
    parameter int OUTER_WIDTH = 64
) (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic [$clog2(OUTER_WIDTH)-1:0] port0_rindex,
    output logic [INNER_WIDTH-1:0]         port0_rdata,
    input  logic [$clog2(OUTER_WIDTH)-1:0] port1_rindex,
    output logic [INNER_WIDTH-1:0]         port1_rdata,
    input  logic                           wen,
    input  logic [$clog2(OUTER_WIDTH)-1:0] windex,
    input  logic [INNER_WIDTH-1:0]         wdata
);

    logic [INNER_WIDTH-1:0] mem [OUTER_WIDTH];

    // reads follow the index in the same cycle
    assign port0_rdata = mem[port0_rindex];
    assign port1_rdata = mem[port1_rindex];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < OUTER_WIDTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wen) begin
            mem[windex] <= wdata;
        end
    end

    a_windex_range: assert property (@(posedge CLK) disable iff (!nRST)
        wen |-> (int'(windex) < OUTER_WIDTH));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the btb testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module btb_tb -f btb_top.f -o btb_sim

./obj_dir/btb_sim | tee sim.log

if grep -q "^TESTS PASSED$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== tb/btb_tb.sv ====
// ----------------------------------------
// testbench for the branch target buffer
// reference model, LFSR, compare tasks
// and the directed tests
// ----------------------------------------
`default_nettype none
`timescale 1ns/100ps

module btb_tb;

    localparam int SETS        = btb_cfg_pkg::BTB_SETS_DEFAULT;
    localparam int ENTRIES     = btb_cfg_pkg::BTB_ENTRIES_DEFAULT;
    localparam int LOG_ENTRIES = $clog2(ENTRIES);
    localparam int TAG_LSB     = 1 + LOG_ENTRIES + $clog2(SETS);
    localparam int TIMEOUT     = 16;

    logic CLK;
    logic nRST;
    btb_types_pkg::btb_req_t     req;
    btb_types_pkg::btb_update0_t update0;
    btb_types_pkg::btb_update1_t update1;
    logic                                  valid_resp;
    logic [ENTRIES-1:0]                    hit;
    logic [ENTRIES-1:0][btb_cfg_pkg::BTB_PRED_INFO_WIDTH-1:0] pred_info;
    btb_types_pkg::btb_way_e [ENTRIES-1:0] pred_lru;
    logic [ENTRIES-1:0][btb_cfg_pkg::BTB_TARGET_WIDTH-1:0]    target;

    // model of both arrays, all zero after reset
    btb_types_pkg::btb_entry_t model_entry [SETS][ENTRIES][2];
    btb_types_pkg::btb_way_e   model_lru [SETS][ENTRIES];

    // expected RESP of the request in flight, tag field unused
    logic                      exp_hit [ENTRIES];
    btb_types_pkg::btb_entry_t exp_data [ENTRIES];
    btb_types_pkg::btb_way_e   exp_lru [ENTRIES];

    int          mismatch_count;
    int          failure_count;
    logic [31:0] lfsr_state;

    btb_top uut (
        .CLK(CLK), .nRST(nRST), .req(req), .update0(update0), .update1(update1),
        .valid_resp(valid_resp), .hit(hit), .pred_info(pred_info),
        .pred_lru(pred_lru), .target(target)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // ----------------------------------------
    // stimulus helpers and reference model
    // ----------------------------------------

    // galois LFSR, taps x^32+x^22+x^2+x+1
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // few tags, few sets, any slot, so hits happen often
    function automatic logic [31:0] random_pc();
        return (random_bits(2) << TAG_LSB) | (random_bits(2) << (LOG_ENTRIES + 1))
            | (random_bits(LOG_ENTRIES) << 1);
    endfunction

    // upper pc bits in 8 bit chunks, XOR together, then the low asid byte
    function automatic logic [7:0] fold_tag(input logic [31:0] pc, input logic [8:0] asid);
        logic [31:0] upper;
        logic [7:0]  t;
        upper = pc >> TAG_LSB;
        t = asid[7:0];
        for (int c = 0; c < 4; c++) begin
            t = t ^ upper[c*8 +: 8];
        end
        return t;
    endfunction

    task automatic model_write(input logic [31:0] pc, input logic [8:0] asid,
                               input logic [7:0] pi, input btb_types_pkg::btb_way_e way,
                               input logic [31:0] tgt);
        int s;
        int e;
        s = int'(pc[TAG_LSB-1:LOG_ENTRIES+1]);
        e = int'(pc[LOG_ENTRIES:1]);
        model_entry[s][e][int'(way)].pred_info = pi;
        model_entry[s][e][int'(way)].tag       = fold_tag(pc, asid);
        model_entry[s][e][int'(way)].target    = tgt[16:1];
        model_lru[s][e] = way;
    endtask

    // way 0 first, miss shows way 0 and the stored hint
    task automatic expect_lookup(input logic [31:0] pc, input logic [8:0] asid);
        int         s;
        logic [7:0] t;
        s = int'(pc[TAG_LSB-1:LOG_ENTRIES+1]);
        t = fold_tag(pc, asid);
        for (int i = 0; i < ENTRIES; i++) begin
            if (model_entry[s][i][0].tag == t) begin
                exp_hit[i]  = 1'b1;
                exp_data[i] = model_entry[s][i][0];
                exp_lru[i]  = btb_types_pkg::WAY0;
            end else if (model_entry[s][i][1].tag == t) begin
                exp_hit[i]  = 1'b1;
                exp_data[i] = model_entry[s][i][1];
                exp_lru[i]  = btb_types_pkg::WAY1;
            end else begin
                exp_hit[i]  = 1'b0;
                exp_data[i] = model_entry[s][i][0];
                exp_lru[i]  = model_lru[s][i];
            end
            exp_data[i].tag = '0;
        end
    endtask

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mismatch_count++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic compare_entry(input string name, input btb_types_pkg::btb_entry_t exp,
                                 input btb_types_pkg::btb_entry_t act);
        if (act !== exp) begin
            mismatch_count++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_way(input string name, input btb_types_pkg::btb_way_e exp,
                               input btb_types_pkg::btb_way_e act);
        if (act !== exp) begin
            mismatch_count++;
            $display("mismatch %s: expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_response(input string name);
        btb_types_pkg::btb_entry_t act;
        for (int i = 0; i < ENTRIES; i++) begin
            act.pred_info = pred_info[i];
            act.tag       = '0;
            act.target    = target[i];
            compare_bit($sformatf("%s slot %0d hit", name, i), exp_hit[i], hit[i]);
            compare_entry($sformatf("%s slot %0d data", name, i), exp_data[i], act);
            compare_way($sformatf("%s slot %0d lru", name, i), exp_lru[i], pred_lru[i]);
        end
    endtask

    // RESP is due at the first falling edge after the sampling edge
    task automatic wait_response(input string name);
        int cycles;
        cycles = 1;
        while (valid_resp !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (valid_resp !== 1'b1) begin
            failure_count++;
            $display("%s: no response within %0d cycles", name, TIMEOUT);
        end else if (cycles != 1) begin
            failure_count++;
            $display("%s: response came %0d cycles after the request", name, cycles);
        end
    endtask

    // ----------------------------------------
    // bus drivers
    // ----------------------------------------

    task automatic lookup(input string name, input logic [31:0] pc, input logic [8:0] asid);
        @(negedge CLK);
        req.valid     = 1'b1;
        req.full_pc   = pc;
        req.asid      = asid;
        update0.valid = 1'b0;
        expect_lookup(pc, asid);
        @(negedge CLK);
        req.valid = 1'b0;
        wait_response(name);
        check_response(name);
    endtask

    // update 0 then update 1, lands on the edge after this task
    task automatic update(input logic [31:0] pc, input logic [8:0] asid, input logic [7:0] pi,
                          input btb_types_pkg::btb_way_e way, input logic [31:0] tgt);
        @(negedge CLK);
        req.valid        = 1'b0;
        req.asid         = asid;
        update0.valid    = 1'b1;
        update0.start_pc = pc;
        @(negedge CLK);
        update0.valid     = 1'b0;
        update1.pred_info = pi;
        update1.lru       = way;
        update1.target_pc = tgt;
        model_write(pc, asid, pi, way, tgt);
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------

    task automatic test_reset();
        compare_bit("reset valid_resp", 1'b0, valid_resp);
        // upper bits and asid zero, tag 0 hits the cleared table
        lookup("reset zero tag", 32'h0000_0026, 9'h000);
        lookup("reset other tag", 32'h0001_2346, 9'h055);
    endtask

    task automatic test_write_hit();
        update(32'h0004_1a36, 9'h0a5, 8'h3c, btb_types_pkg::WAY1, 32'h0000_9abc);
        lookup("write hit", 32'h0004_1a36, 9'h0a5);
        compare_bit("write hit slot 3 hit", 1'b1, hit[3]);
        compare_way("write hit slot 3 lru", btb_types_pkg::WAY1, pred_lru[3]);
    endtask

    task automatic test_asid_miss();
        lookup("asid miss", 32'h0004_1a36, 9'h0a4);
        compare_bit("asid miss slot 3 hit", 1'b0, hit[3]);
    endtask

    task automatic test_way_priority();
        update(32'h0023_4458, 9'h0f0, 8'h11, btb_types_pkg::WAY1, 32'h0000_1110);
        update(32'h0023_4458, 9'h0f0, 8'h22, btb_types_pkg::WAY0, 32'h0000_2220);
        lookup("both ways", 32'h0023_4458, 9'h0f0);
        compare_way("both ways slot 4 lru", btb_types_pkg::WAY0, pred_lru[4]);
        update(32'h0000_0c52, 9'h0f0, 8'h33, btb_types_pkg::WAY1, 32'h0000_3330);
        lookup("way 1 only", 32'h0000_0c52, 9'h0f0);
        compare_way("way 1 only slot 1 lru", btb_types_pkg::WAY1, pred_lru[1]);
    endtask

    // slot 6 of the set that slot 3 sits in
    task automatic test_slot_isolation();
        update(32'h0004_1a3c, 9'h0a5, 8'h5a, btb_types_pkg::WAY0, 32'h0000_7654);
        lookup("slot isolation", 32'h0004_1a36, 9'h0a5);
        compare_bit("slot isolation slot 3 hit", 1'b1, hit[3]);
        // a miss shows the stored hint of slot 3
        lookup("slot isolation miss", 32'h0004_1a36, 9'h0a4);
        compare_way("slot isolation slot 3 lru", btb_types_pkg::WAY1, pred_lru[3]);
    endtask

    // one cycle per step, responses checked one cycle after their request
    task automatic test_random_traffic();
        logic        resp_due;
        logic        u0_pending;
        logic [31:0] u0_pc;
        logic [8:0]  u0_asid;
        logic [31:0] r;
        logic [8:0]  asid;
        resp_due   = 1'b0;
        u0_pending = 1'b0;
        u0_pc      = '0;
        u0_asid    = '0;
        for (int n = 0; n <= 300; n++) begin
            @(negedge CLK);
            // no request last cycle means no response now
            compare_bit("random valid_resp", resp_due, valid_resp);
            if (resp_due) begin
                check_response("random");
            end
            asid = lfsr_bit() ? 9'h1c3 : 9'h000;
            req.valid   = (n < 300) && (lfsr_bit() | lfsr_bit());
            req.full_pc = random_pc();
            req.asid    = asid;
            resp_due    = req.valid;
            // request sampled on the write edge sees the old entry
            if (req.valid) begin
                expect_lookup(req.full_pc, asid);
            end
            if (u0_pending) begin
                r = random_bits(8);
                update1.pred_info = r[7:0];
                update1.lru       = btb_types_pkg::btb_way_e'(lfsr_bit());
                update1.target_pc = random_bits(32);
                model_write(u0_pc, u0_asid, update1.pred_info, update1.lru,
                            update1.target_pc);
            end
            update0.valid    = (n < 300) && lfsr_bit();
            update0.start_pc = random_pc();
            u0_pending = update0.valid;
            u0_pc      = update0.start_pc;
            u0_asid    = asid;
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial begin
        nRST           = 1'b0;
        req            = '0;
        update0        = '0;
        update1        = '0;
        mismatch_count = 0;
        failure_count  = 0;
        lfsr_state     = 32'h792d;
        for (int s = 0; s < SETS; s++) begin
            for (int e = 0; e < ENTRIES; e++) begin
                model_entry[s][e][0] = '0;
                model_entry[s][e][1] = '0;
                model_lru[s][e]      = btb_types_pkg::WAY0;
            end
        end
        repeat (8) begin
            @(negedge CLK);
            compare_bit("valid_resp in reset", 1'b0, valid_resp);
        end
        nRST = 1'b1;
        @(negedge CLK);
        test_reset();
        test_write_hit();
        test_asid_miss();
        test_way_priority();
        test_slot_isolation();
        test_random_traffic();
        @(negedge CLK);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog for the whole run
    initial begin
        repeat (5000) @(posedge CLK);
        $display("simulation did not finish within 5000 cycles");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
